// File: Makefile
TOP = IssueSchedulerTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f issueScheduler.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "^Verification passed$$" > /dev/null

clean:
	rm -rf obj_dir

// File: design/IssueQueue.sv
// ################################################
// Issue queue: entry storage, allocation,
// wakeup tag match and freeing of issued entries
// ################################################

module IssueQueue #(
    parameter int ENTRY_NUM = SchedulerTypes::DEFAULT_ENTRY_NUM,
    parameter int ISSUE_WIDTH = SchedulerTypes::DEFAULT_INT_ISSUE_WIDTH
        + SchedulerTypes::DEFAULT_MEM_ISSUE_WIDTH
)(
    input logic clk,
    input logic rstN,
    input logic dispatchValid,
    input SchedulerTypes::PipeKindPath dispatchPipe,
    input SchedulerTypes::TagPath dispatchSrcTag,
    input logic dispatchSrcReady,
    input SchedulerTypes::TagPath dispatchDestTag,
    input logic wakeupValid,
    input SchedulerTypes::TagPath wakeupTag,
    output logic full,
    output logic [ISSUE_WIDTH-1:0] issueValid,
    output SchedulerTypes::TagPath [ISSUE_WIDTH-1:0] issueDestTag,
    WakeupSelectIF.IssueQueue port
);

    import SchedulerTypes::*;

    logic [ENTRY_NUM-1:0] validQ;
    logic [ENTRY_NUM-1:0] readyQ;
    PipeKindPath pipeQ [ENTRY_NUM];
    TagPath srcTagQ [ENTRY_NUM];
    TagPath destTagQ [ENTRY_NUM];

    logic [ENTRY_NUM-1:0] freeVector;
    logic [ENTRY_NUM-1:0] allocVector;
    logic [ENTRY_NUM-1:0] wakeupHit;
    logic allocate;
    logic dispatchWakeup;

    // Lowest free entry as a one-hot mask
    assign freeVector = ~validQ;
    assign allocVector = freeVector & (~freeVector + 1'b1);
    assign full = &validQ;
    assign allocate = dispatchValid && !full;

    // A wakeup in the dispatch cycle also counts
    assign dispatchWakeup = wakeupValid && (wakeupTag == dispatchSrcTag);

    always_comb begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            wakeupHit[i] = validQ[i] && wakeupValid && (srcTagQ[i] == wakeupTag);
            port.intIssueReq[i] = validQ[i] && (pipeQ[i] == PIPE_INT);
            port.memIssueReq[i] = validQ[i] && (pipeQ[i] == PIPE_MEM);
        end
    end

    assign port.opReady = readyQ;

    // Allocation never hits a granted entry since granted entries are still valid
    always_ff @(posedge clk) begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            if (!rstN) begin
                validQ[i] <= 1'b0;
            end else if (allocate && allocVector[i]) begin
                validQ[i] <= 1'b1;
            end else if (port.selectedVector[i]) begin
                validQ[i] <= 1'b0;
            end
        end
    end

    // Ready bit lives and dies with its entry
    always_ff @(posedge clk) begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            if (!rstN) begin
                readyQ[i] <= 1'b0;
            end else if (allocate && allocVector[i]) begin
                readyQ[i] <= dispatchSrcReady || dispatchWakeup;
                pipeQ[i] <= dispatchPipe;
                srcTagQ[i] <= dispatchSrcTag;
                destTagQ[i] <= dispatchDestTag;
            end else if (port.selectedVector[i]) begin
                readyQ[i] <= 1'b0;
            end else if (wakeupHit[i]) begin
                readyQ[i] <= 1'b1;
            end
        end
    end

    // Issue slots straight from the select result
    always_comb begin
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            issueValid[s] = port.selected[s];
            issueDestTag[s] = destTagQ[port.selectedPtr[s]];
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (port.selectedVector & ~validQ) == '0)
    else $error("IssueQueue: freeing invalid entries %b", port.selectedVector & ~validQ);

    assert property (@(posedge clk) disable iff (!rstN)
        (port.opReady & ~validQ) == '0)
    else $error("IssueQueue: ready without valid %b", port.opReady & ~validQ);

endmodule : IssueQueue

// File: design/IssueScheduler.sv
// ################################################
// Scheduler top level with plain ports, issue
// queue and select logic joined by the interface
// ################################################

module IssueScheduler #(
    parameter int ENTRY_NUM = SchedulerTypes::DEFAULT_ENTRY_NUM,
    parameter int INT_ISSUE_WIDTH = SchedulerTypes::DEFAULT_INT_ISSUE_WIDTH,
    parameter int MEM_ISSUE_WIDTH = SchedulerTypes::DEFAULT_MEM_ISSUE_WIDTH,
    localparam int ISSUE_WIDTH = INT_ISSUE_WIDTH + MEM_ISSUE_WIDTH
)(
    input logic clk,
    input logic rstN,
    input logic dispatchValid,
    input SchedulerTypes::PipeKindPath dispatchPipe,
    input SchedulerTypes::TagPath dispatchSrcTag,
    input logic dispatchSrcReady,
    input SchedulerTypes::TagPath dispatchDestTag,
    input logic wakeupValid,
    input SchedulerTypes::TagPath wakeupTag,
    output logic full,
    output logic [ISSUE_WIDTH-1:0] issueValid,
    output SchedulerTypes::TagPath [ISSUE_WIDTH-1:0] issueDestTag
);

    import SchedulerTypes::*;

    WakeupSelectIF #(
        .ENTRY_NUM(ENTRY_NUM),
        .ISSUE_WIDTH(ISSUE_WIDTH)
    ) wakeupSelect (
        .clk(clk),
        .rstN(rstN)
    );

    IssueQueue #(
        .ENTRY_NUM(ENTRY_NUM),
        .ISSUE_WIDTH(ISSUE_WIDTH)
    ) issueQueue (
        .clk(clk),
        .rstN(rstN),
        .dispatchValid(dispatchValid),
        .dispatchPipe(dispatchPipe),
        .dispatchSrcTag(dispatchSrcTag),
        .dispatchSrcReady(dispatchSrcReady),
        .dispatchDestTag(dispatchDestTag),
        .wakeupValid(wakeupValid),
        .wakeupTag(wakeupTag),
        .full(full),
        .issueValid(issueValid),
        .issueDestTag(issueDestTag),
        .port(wakeupSelect)
    );

    SelectLogic #(
        .ENTRY_NUM(ENTRY_NUM),
        .INT_ISSUE_WIDTH(INT_ISSUE_WIDTH),
        .MEM_ISSUE_WIDTH(MEM_ISSUE_WIDTH)
    ) selectLogic (
        .port(wakeupSelect)
    );

endmodule : IssueScheduler

// File: design/Picker.sv
// ################################################
// Lowest-index picker, grants up to GRANT_NUM
// requests out of ENTRY_NUM
// ################################################

module Picker #(
    parameter int ENTRY_NUM = SchedulerTypes::DEFAULT_ENTRY_NUM,
    parameter int GRANT_NUM = SchedulerTypes::DEFAULT_INT_ISSUE_WIDTH,
    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM)
)(
    input logic [ENTRY_NUM-1:0] req,
    output logic [ENTRY_NUM-1:0] grant,
    output logic [GRANT_NUM-1:0][INDEX_WIDTH-1:0] grantPtr,
    output logic [GRANT_NUM-1:0] granted
);

    import SchedulerTypes::*;

    // Scan upward, the n-th set request goes to grant slot n
    always_comb begin
        int count;

        count = 0;
        grant = '0;
        granted = '0;
        grantPtr = '0;

        for (int i = 0; i < ENTRY_NUM; i++) begin
            if (req[i] && count < GRANT_NUM) begin
                grant[i] = 1'b1;
                granted[count] = 1'b1;
                grantPtr[count] = INDEX_WIDTH'(i);
                count++;
            end
        end
    end

    // Output consistency against the request vector
    always_comb begin
        for (int s = 0; s < GRANT_NUM; s++) begin
            if (granted[s]) begin
                assert (req[grantPtr[s]])
                else $error("Picker: slot %0d points to idle entry %0d", s, grantPtr[s]);
            end
        end

        assert ($countones(grant) <= GRANT_NUM)
        else $error("Picker: %0d grants exceed width %0d", $countones(grant), GRANT_NUM);
    end

endmodule : Picker

// File: design/SchedulerTypes.sv
// ################################################
// Scheduler package: tag and pipe kind types,
// pipe kind encodings and default queue sizes
// ################################################

package SchedulerTypes;

    localparam int TAG_WIDTH = 6;

    // Physical register tag
    typedef logic [TAG_WIDTH-1:0] TagPath;

    // Pipe selection of a queue entry
    typedef logic [0:0] PipeKindPath;

    localparam PipeKindPath PIPE_INT = 1'b0;
    localparam PipeKindPath PIPE_MEM = 1'b1;

    // Default sizes used by the top level
    localparam int DEFAULT_ENTRY_NUM = 8;
    localparam int DEFAULT_INT_ISSUE_WIDTH = 2;
    localparam int DEFAULT_MEM_ISSUE_WIDTH = 1;

endpackage : SchedulerTypes

// File: design/SelectLogic.sv
// ################################################
// Select logic: masks requests with readiness,
// one picker per pipe, packs grants into slots
// ################################################

module SelectLogic #(
    parameter int ENTRY_NUM = SchedulerTypes::DEFAULT_ENTRY_NUM,
    parameter int INT_ISSUE_WIDTH = SchedulerTypes::DEFAULT_INT_ISSUE_WIDTH,
    parameter int MEM_ISSUE_WIDTH = SchedulerTypes::DEFAULT_MEM_ISSUE_WIDTH
)(
    WakeupSelectIF.SelectLogic port
);

    import SchedulerTypes::*;

    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM);

    logic [ENTRY_NUM-1:0] intRequest;
    logic [ENTRY_NUM-1:0] memRequest;
    logic [ENTRY_NUM-1:0] intGrant;
    logic [ENTRY_NUM-1:0] memGrant;

    logic [INT_ISSUE_WIDTH-1:0] intSelected;
    logic [INT_ISSUE_WIDTH-1:0][INDEX_WIDTH-1:0] intSelectedPtr;
    logic [MEM_ISSUE_WIDTH-1:0] memSelected;
    logic [MEM_ISSUE_WIDTH-1:0][INDEX_WIDTH-1:0] memSelectedPtr;

    // Only entries with all operands ready may compete
    assign intRequest = port.opReady & port.intIssueReq;
    assign memRequest = port.opReady & port.memIssueReq;

    Picker #(
        .ENTRY_NUM(ENTRY_NUM),
        .GRANT_NUM(INT_ISSUE_WIDTH)
    ) intPicker (
        .req(intRequest),
        .grant(intGrant),
        .grantPtr(intSelectedPtr),
        .granted(intSelected)
    );

    Picker #(
        .ENTRY_NUM(ENTRY_NUM),
        .GRANT_NUM(MEM_ISSUE_WIDTH)
    ) memPicker (
        .req(memRequest),
        .grant(memGrant),
        .grantPtr(memSelectedPtr),
        .granted(memSelected)
    );

    // Integer slots low, memory slots above them
    always_comb begin
        for (int i = 0; i < INT_ISSUE_WIDTH; i++) begin
            port.selected[i] = intSelected[i];
            port.selectedPtr[i] = intSelectedPtr[i];
        end

        for (int i = 0; i < MEM_ISSUE_WIDTH; i++) begin
            port.selected[i+INT_ISSUE_WIDTH] = memSelected[i];
            port.selectedPtr[i+INT_ISSUE_WIDTH] = memSelectedPtr[i];
        end

        port.selectedVector = intGrant | memGrant;
    end

    // Pipe kinds in the queue keep the two pickers apart
    assert property (@(posedge port.clk) disable iff (!port.rstN)
        (intGrant & memGrant) == '0)
    else $error("SelectLogic: entry granted to both pipes, mask %b", intGrant & memGrant);

endmodule : SelectLogic

// File: design/WakeupSelectIF.sv
// ################################################
// Interface between the issue queue and the
// select logic, with one modport per side
// ################################################

interface WakeupSelectIF #(
    parameter int ENTRY_NUM = SchedulerTypes::DEFAULT_ENTRY_NUM,
    parameter int ISSUE_WIDTH = SchedulerTypes::DEFAULT_INT_ISSUE_WIDTH
        + SchedulerTypes::DEFAULT_MEM_ISSUE_WIDTH
)(
    input logic clk,
    input logic rstN
);

    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM);

    // Queue -> select
    logic [ENTRY_NUM-1:0] opReady;
    logic [ENTRY_NUM-1:0] intIssueReq;
    logic [ENTRY_NUM-1:0] memIssueReq;

    // Select -> queue, integer slots first
    logic [ISSUE_WIDTH-1:0] selected;
    logic [ISSUE_WIDTH-1:0][INDEX_WIDTH-1:0] selectedPtr;
    logic [ENTRY_NUM-1:0] selectedVector;

    modport IssueQueue (
        output opReady,
        output intIssueReq,
        output memIssueReq,
        input selected,
        input selectedPtr,
        input selectedVector
    );

    modport SelectLogic (
        input clk,
        input rstN,
        input opReady,
        input intIssueReq,
        input memIssueReq,
        output selected,
        output selectedPtr,
        output selectedVector
    );

endinterface : WakeupSelectIF

// File: issueScheduler.f
design/SchedulerTypes.sv
design/WakeupSelectIF.sv
design/Picker.sv
design/SelectLogic.sv
design/IssueQueue.sv
design/IssueScheduler.sv
verification/IssueSchedulerTb.sv

// File: verification/IssueSchedulerTb.sv
// ################################################
// Testbench for the issue scheduler: clock, reset,
// vector replay, output checks and the report
// ################################################

module IssueSchedulerTb;

    import SchedulerTypes::*;

    localparam int MAX_VECTORS = 64;
    localparam int CLK_PERIOD = 40;
    localparam int ISSUE_WIDTH = DEFAULT_INT_ISSUE_WIDTH + DEFAULT_MEM_ISSUE_WIDTH;

    logic clk;
    logic rstN;
    logic dispatchValid;
    PipeKindPath dispatchPipe;
    TagPath dispatchSrcTag;
    logic dispatchSrcReady;
    TagPath dispatchDestTag;
    logic wakeupValid;
    TagPath wakeupTag;
    logic full;
    logic [ISSUE_WIDTH-1:0] issueValid;
    TagPath [ISSUE_WIDTH-1:0] issueDestTag;

    // Columns: test, 7 stimulus fields, full, issueValid, 3 dest tags
    int vec [MAX_VECTORS][13];
    int vectorCount;
    int passCount;
    int failCount;
    int testErrors;
    bit loaded;

    IssueScheduler DUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic loadVectors();
        int fd;
        int n;
        int f [13];
        string line;

        vectorCount = 0;
        fd = $fopen("verification/issueVectors.txt", "r");
        if (fd == 0) begin
            $display("The vector file verification/issueVectors.txt could not be opened");
        end else begin
            while (!$feof(fd) && vectorCount < MAX_VECTORS) begin
                line = "";
                n = $fgets(line, fd);
                // Comment and blank lines carry no vector
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                        f[7], f[8], f[9], f[10], f[11], f[12]);
                    if (n == 13) begin
                        vec[vectorCount] = f;
                        vectorCount++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic driveRow(int k);
        dispatchValid <= (vec[k][1] != 0);
        dispatchPipe <= PipeKindPath'(vec[k][2]);
        dispatchSrcTag <= TagPath'(vec[k][3]);
        dispatchSrcReady <= (vec[k][4] != 0);
        dispatchDestTag <= TagPath'(vec[k][5]);
        wakeupValid <= (vec[k][6] != 0);
        wakeupTag <= TagPath'(vec[k][7]);
    endtask

    task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
        testErrors++;
    endtask

    task automatic checkRow(int k);
        logic [ISSUE_WIDTH-1:0] expValid;

        expValid = ISSUE_WIDTH'(vec[k][9]);
        assert (full === (vec[k][8] != 0))
        else reportMismatch("full", vec[k][8], 32'(full));
        assert (issueValid === expValid)
        else reportMismatch("issueValid", 32'(expValid), 32'(issueValid));
        // Tags only mean something in a valid slot
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            if (expValid[s]) begin
                assert (issueDestTag[s] === TagPath'(vec[k][10+s]))
                else reportMismatch($sformatf("issueDestTag[%0d]", s), vec[k][10+s],
                    32'(issueDestTag[s]));
            end
        end
    endtask

    task automatic endTest(int num);
        if (testErrors == 0) begin
            $display("Test %0d done, all checks matched", num);
            passCount++;
        end else begin
            $display("Test %0d done with %0d mismatches", num, testErrors);
            failCount++;
        end
        testErrors = 0;
    endtask

    task automatic finishRun();
        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        dispatchValid = 1'b0;
        dispatchPipe = PIPE_INT;
        dispatchSrcTag = '0;
        dispatchSrcReady = 1'b0;
        dispatchDestTag = '0;
        wakeupValid = 1'b0;
        wakeupTag = '0;
        passCount = 0;
        failCount = 0;
        testErrors = 0;
        loadVectors();
        loaded = 1'b1;
        if (vectorCount == 0) begin
            $display("No vectors were read, so no test could run");
            failCount++;
        end else begin
            repeat (5) @(posedge clk);
            rstN <= 1'b1;
            driveRow(0);
            for (int k = 0; k < vectorCount; k++) begin
                @(posedge clk);
                if (k + 1 < vectorCount) begin
                    driveRow(k + 1);
                end else begin
                    dispatchValid <= 1'b0;
                    wakeupValid <= 1'b0;
                end
                // Outputs depend on queue state only, stable here
                @(negedge clk);
                checkRow(k);
                if (k + 1 == vectorCount || vec[k+1][0] != vec[k][0]) begin
                    endTest(vec[k][0]);
                end
            end
        end
        finishRun();
    end

    initial begin
        wait (loaded);
        #((vectorCount + 10) * CLK_PERIOD);
        $display("Timeout, the vectors did not finish within %0d cycles", vectorCount + 10);
        failCount++;
        finishRun();
    end

endmodule : IssueSchedulerTb

// File: verification/issueVectors.txt
# test dv pipe srcTag srcReady destTag wv wakeupTag full issueValid tag0 tag1 tag2
# Test number decimal, the rest hex; expected values hold after the edge taking the stimulus
1 0 0 00 0 00 0 00 0 0 00 00 00
1 1 0 01 1 10 0 00 0 1 10 00 00
1 0 0 00 0 00 0 00 0 0 00 00 00
2 1 0 05 0 11 0 00 0 0 00 00 00
2 0 0 00 0 00 0 00 0 0 00 00 00
2 0 0 00 0 00 1 05 0 1 11 00 00
2 1 0 07 0 12 1 07 0 1 12 00 00
2 0 0 00 0 00 0 00 0 0 00 00 00
3 1 0 20 0 21 0 00 0 0 00 00 00
3 1 0 20 0 22 0 00 0 0 00 00 00
3 1 0 20 0 23 0 00 0 0 00 00 00
3 1 0 20 0 24 0 00 0 0 00 00 00
3 0 0 00 0 00 1 20 0 3 21 22 00
3 0 0 00 0 00 0 00 0 3 23 24 00
3 0 0 00 0 00 0 00 0 0 00 00 00
4 1 1 30 0 31 0 00 0 0 00 00 00
4 1 1 30 0 32 0 00 0 0 00 00 00
4 1 0 30 0 33 0 00 0 0 00 00 00
4 0 0 00 0 00 1 30 0 5 33 00 31
4 0 0 00 0 00 0 00 0 4 00 00 32
4 0 0 00 0 00 0 00 0 0 00 00 00
5 1 0 3A 0 40 0 00 0 0 00 00 00
5 1 0 3A 0 41 0 00 0 0 00 00 00
5 1 1 3A 0 42 0 00 0 0 00 00 00
5 1 0 3A 0 43 0 00 0 0 00 00 00
5 1 1 3A 0 44 0 00 0 0 00 00 00
5 1 0 3A 0 45 0 00 0 0 00 00 00
5 1 1 3A 0 46 0 00 0 0 00 00 00
5 1 0 3A 0 47 0 00 1 0 00 00 00
5 1 0 3A 1 48 0 00 1 0 00 00 00
5 0 0 00 0 00 1 3A 1 7 40 41 42
5 0 0 00 0 00 0 00 0 7 43 45 44
5 0 0 00 0 00 0 00 0 5 47 00 46
5 0 0 00 0 00 0 00 0 0 00 00 00
5 0 0 00 0 00 0 00 0 0 00 00 00
